//--- hw/pic_core_pkg.sv
package pic_core_pkg;

	//////////////////////////////////////////////////////////////////////
	// Request levels
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_LEVELS = 8;    // IR0 has the highest priority.
	localparam int LEVEL_BITS = 3;

	typedef logic [LEVEL_BITS-1:0] level_t;
	typedef logic [NUM_LEVELS-1:0] irq_vec_t;

	localparam level_t SPURIOUS_LEVEL = 3'd7;    // Acknowledge with nothing pending.

	//////////////////////////////////////////////////////////////////////
	// Acknowledge sequencing
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		IDLE = 2'd0,
		ACK1 = 2'd1,    // First inta_n pulse.
		GAP  = 2'd2,
		ACK2 = 2'd3     // Second pulse, vector on the bus.
	} ack_state_e;

endpackage

//--- hw/pic_cmd_pkg.sv
package pic_cmd_pkg;

	//////////////////////////////////////////////////////////////////////
	// Command byte written with a0 low
	//////////////////////////////////////////////////////////////////////

	typedef union packed
	{
		struct packed
		{
			logic [2:0] unused;    // 8080 call address bits.
			logic       marker;    // Set for ICW1.
			logic [1:0] ignored;   // LTIM and ADI.
			logic       sngl;      // No cascade, so ignored.
			logic       ic4;
		} icw1;
		struct packed
		{
			logic [2:0] eoi_code;
			logic       marker;    // Clear for OCW2 and OCW3.
			logic       sel_ocw3;
			union packed
			{
				logic [2:0] eoi_level;
				struct packed
				{
					logic poll;
					logic rr;
					logic ris;
				} rd;
			} low;
		} ocw;
	} cmd_word_u;

	localparam logic [2:0] EOI_NONSPEC   = 3'b001;
	localparam logic [2:0] EOI_SPEC      = 3'b011;
	localparam int         ICW4_AEOI_BIT = 1;
	localparam int         POLL_FLAG     = 7;    // Set in a poll word with a request.

endpackage

//--- hw/pic_cmd_decoder.sv
`timescale 1ns/100ps

module pic_cmd_decoder
	import pic_core_pkg::*;
	import pic_cmd_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       wr,
	input  logic       a0,
	input  logic [7:0] din,
	output logic       ready,
	output logic [4:0] vector_base,
	output logic       aeoi,
	output irq_vec_t   mask,
	output logic       read_isr,
	output logic       poll_cmd,
	output logic       eoi_nonspec,
	output logic       eoi_spec,
	output level_t     eoi_level,
	output logic       init_clear
);

	cmd_word_u cmd;
	logic      expect_icw2;
	logic      expect_icw4;
	logic      ic4;
	logic      icw2_wr;
	logic      icw4_wr;
	logic      ocw1_wr;
	logic      ocw2_wr;
	logic      ocw3_wr;

	assign cmd = din;

	//////////////////////////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////////////////////////

	assign init_clear = wr && !a0 && cmd.icw1.marker;    // ICW1 restarts everything.
	assign icw2_wr    = wr && a0 && expect_icw2;
	assign icw4_wr    = wr && a0 && expect_icw4;
	assign ocw1_wr    = wr && a0 && ready;
	assign ocw2_wr    = wr && !a0 && ready && !cmd.ocw.marker && !cmd.ocw.sel_ocw3;
	assign ocw3_wr    = wr && !a0 && ready && !cmd.ocw.marker && cmd.ocw.sel_ocw3;

	assign eoi_nonspec = ocw2_wr && (cmd.ocw.eoi_code == EOI_NONSPEC);
	assign eoi_spec    = ocw2_wr && (cmd.ocw.eoi_code == EOI_SPEC);
	assign eoi_level   = cmd.ocw.low.eoi_level;
	assign poll_cmd    = ocw3_wr && cmd.ocw.low.rd.poll;

	//////////////////////////////////////////////////////////////////////
	// Initialization sequence and configuration
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ready       <= 1'b0;
			expect_icw2 <= 1'b0;
			expect_icw4 <= 1'b0;
			ic4         <= 1'b0;
			aeoi        <= 1'b0;
		end
		else if (init_clear)
		begin
			ready       <= 1'b0;
			expect_icw2 <= 1'b1;
			expect_icw4 <= 1'b0;
			ic4         <= cmd.icw1.ic4;
			aeoi        <= 1'b0;
		end
		else if (icw2_wr)
		begin
			expect_icw2 <= 1'b0;
			expect_icw4 <= ic4;
			ready       <= !ic4;    // Done here unless ICW4 follows.
		end
		else if (icw4_wr)
		begin
			expect_icw4 <= 1'b0;
			ready       <= 1'b1;
			aeoi        <= din[ICW4_AEOI_BIT];
		end
	end

	always_ff @(posedge clk)
	begin
		if (icw2_wr)
			vector_base <= din[7:3];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mask     <= '1;
			read_isr <= 1'b0;
		end
		else if (init_clear)
		begin
			mask     <= '0;
			read_isr <= 1'b0;
		end
		else if (ocw1_wr)
			mask <= din;
		else if (ocw3_wr && cmd.ocw.low.rd.rr)
			read_isr <= cmd.ocw.low.rd.ris;    // RIS only counts with RR.
	end

endmodule

//--- hw/pic_request_reg.sv
`timescale 1ns/100ps

module pic_request_reg
	import pic_core_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  irq_vec_t ir,
	input  irq_vec_t irr_clear,
	input  logic     init_clear,
	output irq_vec_t irr
);

	irq_vec_t ir_q;
	irq_vec_t ir_rise;

	assign ir_rise = ir & ~ir_q;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ir_q <= '0;
			irr  <= '0;
		end
		else
		begin
			ir_q <= ir;
			if (init_clear)
				irr <= '0;
			else
				irr <= (irr & ~irr_clear) | ir_rise;    // Held until acknowledged.
		end
	end

endmodule

//--- hw/pic_service_ctrl.sv
`timescale 1ns/100ps

module pic_service_ctrl
	import pic_core_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  irq_vec_t irr,
	input  irq_vec_t mask,
	input  logic     ready,
	input  logic     aeoi,
	input  logic     take,
	input  logic     ack_end,
	input  logic     eoi_nonspec,
	input  logic     eoi_spec,
	input  level_t   eoi_level,
	input  logic     init_clear,
	output irq_vec_t isr,
	output logic     pending_valid,
	output level_t   pending_level,
	output irq_vec_t irr_clear,
	output logic     int_out
);

	irq_vec_t req;
	level_t   isr_level;
	irq_vec_t isr_set;
	irq_vec_t isr_clr;
	irq_vec_t taken;

	function automatic level_t first_set(input irq_vec_t vec);
		level_t lvl;
		lvl = '0;
		for (int i = NUM_LEVELS - 1; i >= 0; i--)
		begin
			if (vec[i])
				lvl = level_t'(i);
		end
		return lvl;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Priority resolution
	//////////////////////////////////////////////////////////////////////

	assign req           = irr & ~mask;
	assign pending_level = first_set(req);
	assign isr_level     = first_set(isr);

	// A request has to outrank every level already in service.
	assign pending_valid = ready && (req != '0) && ((isr == '0) || (pending_level < isr_level));

	assign isr_set   = (take && pending_valid) ? (irq_vec_t'(1) << pending_level) : '0;
	assign irr_clear = isr_set;

	always_comb
	begin
		isr_clr = '0;
		if (eoi_nonspec && (isr != '0))
			isr_clr[isr_level] = 1'b1;
		if (eoi_spec)
			isr_clr[eoi_level] = 1'b1;
		if (ack_end && aeoi)
			isr_clr = isr_clr | taken;    // Spurious acks leave taken empty.
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			isr     <= '0;
			taken   <= '0;
			int_out <= 1'b0;
		end
		else
		begin
			int_out <= pending_valid;
			if (init_clear)
				isr <= '0;
			else
				isr <= (isr & ~isr_clr) | isr_set;
			if (take)
				taken <= isr_set;
		end
	end

endmodule

//--- hw/pic_ack_sequencer.sv
`timescale 1ns/100ps

module pic_ack_sequencer
	import pic_core_pkg::*;
	import pic_cmd_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       inta_n,
	input  logic       rd,
	input  logic       a0,
	input  logic       poll_cmd,
	input  logic       read_isr,
	input  irq_vec_t   irr,
	input  irq_vec_t   isr,
	input  irq_vec_t   mask,
	input  logic [4:0] vector_base,
	input  logic       pending_valid,
	input  level_t     pending_level,
	output logic       take,
	output logic       ack_end,
	output logic [7:0] dout,
	output logic       dout_en
);

	ack_state_e state;
	ack_state_e state_next;
	logic       inta_q;
	logic       inta_fall;
	logic       inta_rise;
	logic       ack_take;
	logic       poll_armed;
	logic       poll_take;
	level_t     ack_level;
	logic [7:0] poll_word;
	logic [7:0] rd_data;

	assign inta_fall = inta_q && !inta_n;
	assign inta_rise = !inta_q && inta_n;
	assign poll_take = rd && poll_armed && pending_valid;
	assign take      = ack_take || poll_take;
	assign ack_end   = (state == ACK2) && inta_rise;

	//////////////////////////////////////////////////////////////////////
	// inta_n pulse tracking
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
				if (inta_fall)
					state_next = ACK1;
			ACK1:
				if (inta_rise)
					state_next = GAP;
			GAP:
				if (inta_fall)
					state_next = ACK2;
			ACK2:
				if (inta_rise)
					state_next = IDLE;
		endcase
	end

	// Poll word, or the selected register.
	always_comb
	begin
		poll_word = '0;
		if (pending_valid)
		begin
			poll_word[POLL_FLAG]      = 1'b1;
			poll_word[LEVEL_BITS-1:0] = pending_level;
		end
		if (poll_armed)
			rd_data = poll_word;
		else if (a0)
			rd_data = mask;
		else if (read_isr)
			rd_data = isr;
		else
			rd_data = irr;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state      <= IDLE;
			inta_q     <= 1'b1;
			ack_take   <= 1'b0;
			poll_armed <= 1'b0;
			dout_en    <= 1'b0;
		end
		else
		begin
			state    <= state_next;
			inta_q   <= inta_n;
			ack_take <= (state == IDLE) && inta_fall;    // First falling edge, one cycle late.
			dout_en  <= rd || (state_next == ACK2);
			if (poll_cmd)
				poll_armed <= 1'b1;
			else if (rd)
				poll_armed <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ack_take)
			ack_level <= pending_valid ? pending_level : SPURIOUS_LEVEL;
		dout <= rd ? rd_data : {vector_base, ack_level};
	end

endmodule

//--- hw/pic_top.sv
`timescale 1ns/100ps

module pic_top
	import pic_core_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       wr,
	input  logic       rd,
	input  logic       a0,
	input  logic [7:0] din,
	input  irq_vec_t   ir,
	input  logic       inta_n,
	output logic [7:0] dout,
	output logic       dout_en,
	output logic       int_out
);

	//////////////////////////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////////////////////////

	logic       ready;
	logic [4:0] vector_base;
	logic       aeoi;
	irq_vec_t   mask;
	logic       read_isr;
	logic       poll_cmd;
	logic       eoi_nonspec;
	logic       eoi_spec;
	level_t     eoi_level;
	logic       init_clear;
	irq_vec_t   irr;
	irq_vec_t   irr_clear;
	irq_vec_t   isr;
	logic       pending_valid;
	level_t     pending_level;
	logic       take;
	logic       ack_end;

	//////////////////////////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////////////////////////

	pic_cmd_decoder pic_cmd_decoder_inst (.*);

	pic_request_reg pic_request_reg_inst (.*);

	pic_service_ctrl pic_service_ctrl_inst (.*);    // Drives int_out.

	pic_ack_sequencer pic_ack_sequencer_inst (.*);    // Drives dout and dout_en.

endmodule

//--- test/pic_properties.sv
`timescale 1ns/100ps

module pic_properties
(
	input logic clk,
	input logic arst_n,
	input logic inta_n,
	input logic dout_en,
	input logic take,
	input logic ack_end
);

	//////////////////////////////////////////////////////////////////////
	// Sequencer properties
	//////////////////////////////////////////////////////////////////////

	// Only the vector stays on dout for more than one cycle.
	dout_en_burst: assert property (@(posedge clk) disable iff (!arst_n)
		dout_en && $past(dout_en) |-> !inta_n || !$past(inta_n))
		else $error("dout_en high for two cycles outside an acknowledge");

	take_single: assert property (@(posedge clk) disable iff (!arst_n)
		take |=> !take)
		else $error("take wider than one cycle");

	ack_end_apart: assert property (@(posedge clk) disable iff (!arst_n)
		!(ack_end && take))
		else $error("ack_end and take in the same cycle");

endmodule

//--- test/pic_checker.sv
`timescale 1ns/100ps

module pic_checker
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       wr,
	input  logic       rd,
	input  logic       a0,
	input  logic [7:0] din,
	input  logic [7:0] ir,
	input  logic       inta_n,
	input  logic [7:0] dout,
	input  logic       dout_en,
	input  logic       int_out,
	input  int         test_id,
	input  logic       test_end,
	output int         checks,
	output int         errors
);

	int          n_checks = 0;
	int          n_errors = 0;
	int          t_checks = 0;
	int          t_errors = 0;
	int          quiet;
	logic        ready, exp_icw2, exp_icw4, ic4, aeoi, read_isr, poll_armed;
	logic        inta_q, take_due, taken_v, exp_rd_valid, exp_int;
	logic        pend_v, blocked, init;
	logic [2:0]  pend_l, ack_level;
	logic [1:0]  phase;    // 0 idle, 1 first pulse, 2 gap, 3 second pulse.
	logic [4:0]  vbase;
	logic [7:0]  mask, irr, isr, ir_q, exp_rd_data, set_m, clr_m;
	logic [19:0] prev_in;

	assign checks = n_checks;
	assign errors = n_errors;

	function automatic string test_name(input int id);
		case (id)
			0:       return "init_vector";
			1:       return "masking";
			2:       return "priority_nesting";
			3:       return "eoi";
			4:       return "auto_eoi";
			default: return "poll_spurious";
		endcase
	endfunction

	task automatic compare(input string what, input logic [7:0] exp, input logic [7:0] act);
		n_checks++;
		t_checks++;
		if (exp !== act)
		begin
			n_errors++;
			t_errors++;
			$display("MISMATCH %s %s: expected %h, actual %h", test_name(test_id), what, exp, act);
		end
	endtask

	task automatic report(input string msg);
		n_errors++;
		t_errors++;
		$display("%s: %s", test_name(test_id), msg);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			{ready, exp_icw2, exp_icw4, ic4, aeoi, read_isr, poll_armed} = '0;
			{take_due, taken_v, exp_rd_valid, exp_int} = '0;
			inta_q = 1'b1;
			phase = 2'd0;
			ack_level = 3'd0;
			vbase = 5'd0;
			mask = 8'hff;
			{irr, isr, ir_q, exp_rd_data} = '0;
			quiet = 0;
			prev_in = '0;
		end
		else
		begin
			// Outputs produced at the previous edge.
			if (exp_rd_valid)
			begin
				if (!dout_en)
					report("no read data the cycle after rd");
				else
					compare("read", exp_rd_data, dout);
			end
			else if (phase == 2'd3)
			begin
				if (!dout_en)
					report("vector not driven during the second inta_n pulse");
				else
					compare("vector", {vbase, ack_level}, dout);
			end
			else if (dout_en)
				report("dout_en high outside a read or an acknowledge");
			if (quiet >= 2)
				compare("int_out", {7'd0, exp_int}, {7'd0, int_out});

			// Highest unmasked request above every level in service.
			pend_v = 1'b0;
			pend_l = 3'd0;
			blocked = 1'b0;
			for (int i = 0; i < 8; i++)
			begin
				if (ready && !blocked && !pend_v)
				begin
					if (isr[i])
						blocked = 1'b1;
					else if (irr[i] && !mask[i])
					begin
						pend_v = 1'b1;
						pend_l = 3'(i);
					end
				end
			end

			set_m = '0;
			clr_m = '0;
			init = 1'b0;
			exp_rd_valid = rd;
			if (rd)
			begin
				if (poll_armed)
				begin
					exp_rd_data = pend_v ? {5'b10000, pend_l} : 8'h00;
					if (pend_v)
						set_m[pend_l] = 1'b1;
				end
				else if (a0)
					exp_rd_data = mask;
				else if (read_isr)
					exp_rd_data = isr;
				else
					exp_rd_data = irr;
				poll_armed = 1'b0;
			end
			if (take_due)
			begin
				ack_level = pend_v ? pend_l : 3'd7;    // Spurious level.
				taken_v = pend_v;
				if (pend_v)
					set_m[pend_l] = 1'b1;
			end
			take_due = 1'b0;

			if (inta_q && !inta_n)
			begin
				if (phase == 2'd0)
				begin
					phase = 2'd1;
					take_due = 1'b1;
				end
				else if (phase == 2'd2)
					phase = 2'd3;
			end
			else if (!inta_q && inta_n)
			begin
				if (phase == 2'd1)
					phase = 2'd2;
				else if (phase == 2'd3)
				begin
					phase = 2'd0;
					if (aeoi && taken_v)
						clr_m[ack_level] = 1'b1;
				end
			end
			inta_q = inta_n;

			if (wr)
			begin
				if (!a0 && din[4])
				begin
					init = 1'b1;
					{ready, exp_icw2, exp_icw4, ic4} = {3'b010, din[0]};
					{aeoi, read_isr} = 2'b00;
					mask = 8'h00;
				end
				else if (a0 && exp_icw2)
				begin
					vbase = din[7:3];
					exp_icw2 = 1'b0;
					exp_icw4 = ic4;
					ready = !ic4;
				end
				else if (a0 && exp_icw4)
				begin
					exp_icw4 = 1'b0;
					ready = 1'b1;
					aeoi = din[1];
				end
				else if (a0 && ready)
					mask = din;
				else if (ready && !din[3] && din[7:5] == 3'b001 && isr != 8'h00)
				begin
					blocked = 1'b0;
					for (int i = 0; i < 8; i++)
					begin
						if (isr[i] && !blocked)
						begin
							clr_m[i] = 1'b1;
							blocked = 1'b1;
						end
					end
				end
				else if (ready && !din[3] && din[7:5] == 3'b011)
					clr_m[din[2:0]] = 1'b1;
				else if (ready && din[3])
				begin
					if (din[2])
						poll_armed = 1'b1;
					if (din[1])
						read_isr = din[0];
				end
			end

			if (init)
			begin
				isr = 8'h00;
				irr = 8'h00;
			end
			else
			begin
				isr = (isr & ~clr_m) | set_m;
				irr = (irr & ~set_m) | (ir & ~ir_q);
			end
			ir_q = ir;
			exp_int = pend_v;

			if ({wr, rd, a0, din, ir, inta_n} != prev_in)
				quiet = 0;
			else if (quiet < 2)
				quiet++;
			prev_in = {wr, rd, a0, din, ir, inta_n};

			if (test_end)
			begin
				$display("Test %0d %s %s: %0d checks, %0d errors", test_id, test_name(test_id),
					(t_errors == 0) ? "ok" : "FAILED", t_checks, t_errors);
				t_checks = 0;
				t_errors = 0;
			end
		end
	end

endmodule

//--- test/pic_tb.sv
`timescale 1ns/100ps

module pic_tb;

	localparam int NUM_TESTS   = 6;
	localparam int CYCLE_LIMIT = NUM_TESTS * 400;

	logic       clk;
	logic       arst_n;
	logic       wr;
	logic       rd;
	logic       a0;
	logic [7:0] din;
	logic [7:0] ir;
	logic       inta_n;
	logic [7:0] dout;
	logic       dout_en;
	logic       int_out;
	logic       test_end;
	logic [7:0] b;
	int         test_id;
	int         checks;
	int         errors;
	int         tb_errors;
	int         cycles;
	int         seed;

	pic_top pic_top_inst (.*);

	pic_checker pic_checker_inst (.*);

	bind pic_ack_sequencer pic_properties pic_properties_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles == CYCLE_LIMIT)
		begin
			$display("Timeout: the run hung after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus tasks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic write_reg(input logic addr, input logic [7:0] data);
		@(negedge clk);
		wr = 1'b1;
		a0 = addr;
		din = data;
		@(negedge clk);
		wr = 1'b0;
	endtask

	task automatic read_reg(input logic addr);
		@(negedge clk);
		rd = 1'b1;
		a0 = addr;
		@(negedge clk);
		rd = 1'b0;
	endtask

	task automatic pulse_ir(input logic [7:0] bits);
		@(negedge clk);
		ir = bits;
		idle(2);
		ir = 8'h00;
		idle(1);
	endtask

	// Two inta_n pulses, two cycles low and two high.
	task automatic acknowledge();
		@(negedge clk);
		inta_n = 1'b0;
		idle(2);
		inta_n = 1'b1;
		idle(2);
		inta_n = 1'b0;
		idle(2);
		inta_n = 1'b1;
		idle(3);
	endtask

	task automatic init_device(input logic icw4, input logic auto_eoi);
		logic [7:0] base;
		base = rand_byte();
		write_reg(1'b0, {7'b0001001, icw4});    // ICW1, single.
		write_reg(1'b1, {base[7:3], 3'b000});
		if (icw4)
			write_reg(1'b1, {6'b000000, auto_eoi, 1'b1});
	endtask

	task automatic wait_int();
		int n;
		n = 0;
		while (!int_out && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (!int_out)
		begin
			tb_errors++;
			$display("int_out never rose after a request in test %0d", test_id);
		end
	endtask

	task automatic finish_test();
		idle(4);
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
		test_id++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		{wr, rd, a0, din, ir, test_end} = '0;
		inta_n = 1'b1;
		arst_n = 1'b0;
		test_id = 0;
		tb_errors = 0;
		cycles = 0;
		seed = 32'h5b01_7d99;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		idle(2);

		init_device(1'b0, 1'b0);
		b = rand_byte();
		pulse_ir(8'h01 << b[2:0]);
		wait_int();
		acknowledge();
		write_reg(1'b0, 8'h20);    // Non-specific EOI.
		finish_test();

		init_device(1'b0, 1'b0);
		repeat (6)
		begin
			write_reg(1'b1, rand_byte());
			read_reg(1'b1);
			b = rand_byte();
			pulse_ir(8'h01 << b[2:0]);
			idle(2);
			if (int_out)
			begin
				acknowledge();
				write_reg(1'b0, 8'h20);
			end
		end
		finish_test();

		init_device(1'b0, 1'b0);
		repeat (2)
		begin
			pulse_ir(rand_byte());
			repeat (6)
			begin
				idle(2);
				if (int_out)
				begin
					acknowledge();
					b = rand_byte();
					if (b[3])
						pulse_ir(rand_byte());    // May nest above the level in service.
					write_reg(1'b0, 8'h20);
				end
			end
		end
		finish_test();

		init_device(1'b0, 1'b0);
		repeat (3)
		begin
			pulse_ir(rand_byte());
			idle(2);
			if (int_out)
				acknowledge();
		end
		repeat (4)
		begin
			b = rand_byte();
			if (b[7])
				write_reg(1'b0, 8'h20);
			else
				write_reg(1'b0, {5'b01100, b[2:0]});    // Specific EOI.
			write_reg(1'b0, 8'h0b);
			read_reg(1'b0);
		end
		write_reg(1'b0, 8'h0a);
		read_reg(1'b0);
		finish_test();

		init_device(1'b1, 1'b1);
		repeat (4)
		begin
			pulse_ir(rand_byte());
			idle(2);
			if (int_out)
				acknowledge();
			write_reg(1'b0, 8'h0b);
			read_reg(1'b0);
		end
		finish_test();

		init_device(1'b0, 1'b0);
		repeat (3)
		begin
			pulse_ir(rand_byte());
			write_reg(1'b0, 8'h0c);    // OCW3 poll.
			read_reg(1'b0);
		end
		init_device(1'b0, 1'b0);
		acknowledge();    // Nothing pending.
		finish_test();

		idle(2);
		$display("Summary: %0d tests, %0d checks, %0d errors", test_id, checks,
			errors + tb_errors);
		if (errors + tb_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- pic.f
hw/pic_core_pkg.sv
hw/pic_cmd_pkg.sv
hw/pic_cmd_decoder.sv
hw/pic_request_reg.sv
hw/pic_service_ctrl.sv
hw/pic_ack_sequencer.sv
hw/pic_top.sv
test/pic_properties.sv
test/pic_checker.sv
test/pic_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f pic.f --top-module pic_tb -o pic_sim
	./obj_dir/pic_sim | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir
